// ==== compile.f ====
boot_pkg.sv
boot_id_store.sv
boot_sequencer.sv
host_link.sv
lc_link.sv
secure_mem_port.sv
secure_boot_control.sv
tb_secure_boot_control.sv

// ==== Makefile ====
TOP = tb_secure_boot_control

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== tb_secure_boot_control.sv ====
// Directed testbench for the secure boot control block.
// Models the host GPIO port, the lifecycle controller and the secure memory.
`timescale 1ns/100ps

module tb_secure_boot_control import boot_pkg::*; ();

    // six tests of well under 300 cycles each, plus margin
    localparam int TIMEOUT_CYCLES = 4000;
    localparam gpio_packet_t PKT_FIELDS = {32'h0, 32'hffff_ffff, 24'h0, 6'h3f, 9'h0, 1'b1};

    logic         clk = 1'b0;
    logic         fuse;
    gpio_word_t   gpio_reg_rdata = '0;
    lc_state_t    lc_state;
    logic         lc_done = 1'b0;
    logic         lc_success = 1'b0;
    id_t          lc_transition_id;
    logic         lc_transition_request_in;
    id_t          lc_authentication_id;
    logic         lc_authentication_valid;
    id_t          puf_a;
    id_t          puf_b;
    id_t          rdData = '0;
    logic         rdData_valid = 1'b0;
    logic         gpio_reg_access;
    gpio_packet_t gpio_reg_packet;
    logic         lc_transition_request;
    id_t          lc_identifier;
    logic         rd_en;
    logic         wr_en;
    mem_addr_t    addr;
    id_t          wrData;

    // model state and event logs
    id_t        mem [16];
    id_t        auth_word;      // loaded at address 8 + lc_state during reset
    id_t        chip_word;      // loaded at address 0 during reset
    logic       lc_answer;
    gpio_word_t host_words[$];
    mem_addr_t  rd_addrs[$];
    mem_addr_t  wr_addrs[$];
    id_t        wr_data[$];
    id_t        lc_ids[$];
    int         ack_wait;
    gpio_word_t ack_word;
    logic       rd_busy;
    int         rd_wait;
    int         lc_wait;
    int         cycles = 0;
    logic [15:0] lfsr = 16'd56;

    secure_boot_control u_secure_boot_control (.*);

    always #20 clk = ~clk;

    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic id_t rand_id();
        id_t v;
        for (int i = 0; i < 256; i++) begin
            v[i] = lfsr_bit();
        end
        return v;
    endfunction

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "run stopped after first failure");
    endtask

    task automatic check_word(string name, gpio_word_t got, gpio_word_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_id(string name, id_t got, id_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(string name, mem_addr_t got, mem_addr_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // host, memory and lifecycle models, all sampled and driven 1 ns after the edge
    always @(posedge clk) begin
        #1;
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Simulation timed out after %0d cycles", cycles);
            abort_run();
        end else if (!fuse) begin
            host_words.delete();
            rd_addrs.delete();
            wr_addrs.delete();
            wr_data.delete();
            lc_ids.delete();
            ack_wait       = 0;
            rd_busy        = 1'b0;
            rd_wait        = 0;
            lc_wait        = 0;
            gpio_reg_rdata = '0;
            rdData_valid   = 1'b0;
            lc_done        = 1'b0;
            for (int i = 0; i < 16; i++) begin
                mem[i] = {32{i[3:0], 4'ha}};
            end
            mem[0] = chip_word;
            mem[4'd8 + 4'(lc_state)] = auth_word;
        end else begin
            if (ack_wait > 0) begin
                ack_wait--;
                if (ack_wait == 0) begin
                    gpio_reg_rdata = (ack_word == 32'h10) ? 32'h20 : 32'h2;
                end
            end
            if (gpio_reg_access) begin
                check_bit("gpio_reg_packet spare bits", |(gpio_reg_packet & ~PKT_FIELDS), 1'b0);
                if (gpio_reg_packet[0]) begin
                    check_bit("gpio write type", gpio_reg_packet[15:10] == 6'h0, 1'b1);
                    host_words.push_back(gpio_reg_packet[71:40]);
                    ack_word       = gpio_reg_packet[71:40];
                    ack_wait       = 3;  // host answers a few cycles later
                    gpio_reg_rdata = '0;
                end else begin
                    check_bit("gpio poll type", gpio_reg_packet[15:10] == 6'h5, 1'b1);
                    check_word("gpio poll word", gpio_reg_packet[71:40], '0);
                end
            end
            // access rises with the first request and never drops
            check_bit("gpio_reg_access", gpio_reg_access, host_words.size() != 0);

            rdData_valid = 1'b0;
            if (wr_en) begin
                mem[addr] = wrData;
                wr_addrs.push_back(addr);
                wr_data.push_back(wrData);
            end
            if (rd_en && !rd_busy) begin
                rd_busy = 1'b1;
                rd_wait = 2;
                rd_addrs.push_back(addr);
            end else if (rd_busy && rd_wait > 0) begin
                rd_wait--;
                if (rd_wait == 0) begin
                    rdData       = mem[addr];
                    rdData_valid = 1'b1;
                end
            end else if (!rd_en) begin
                rd_busy = 1'b0;
            end

            lc_done = 1'b0;
            if (lc_transition_request) begin
                lc_ids.push_back(lc_identifier);
                lc_wait = 3;
            end else begin
                check_id("lc_identifier when idle", lc_identifier, '0);
                if (lc_wait > 0) begin
                    lc_wait--;
                    if (lc_wait == 0) begin
                        lc_done    = 1'b1;
                        lc_success = lc_answer;
                    end
                end
            end
        end
    end

    task automatic reset_dut(lc_state_t st);
        fuse                     = 1'b0;
        lc_state                 = st;
        lc_transition_request_in = 1'b0;
        lc_authentication_valid  = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        fuse = 1'b1;
    endtask

    task automatic idle_cycles(int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_host(int n);
        @(posedge clk);
        while (host_words.size() < n) @(posedge clk);
        #1;
    endtask

    task automatic wait_reads(int n);
        @(posedge clk);
        while (rd_addrs.size() < n) @(posedge clk);
        #1;
    endtask

    task automatic wait_writes(int n);
        @(posedge clk);
        while (wr_addrs.size() < n) @(posedge clk);
        #1;
    endtask

    task automatic wait_lc(int n);
        @(posedge clk);
        while (lc_ids.size() < n) @(posedge clk);
        #1;
    endtask

    task automatic request_transition(id_t id, int n);
        lc_transition_id         = id;
        lc_transition_request_in = 1'b1;
        wait_lc(n);
        lc_transition_request_in = 1'b0;
    endtask

    task automatic present_auth(id_t id, int n);
        lc_authentication_id    = id;
        lc_authentication_valid = 1'b1;
        wait_reads(n);
        lc_authentication_valid = 1'b0;
    endtask

    task automatic test_provision();
        puf_a     = rand_id();
        puf_b     = rand_id();
        lc_answer = 1'b1;
        reset_dut(3'd0);
        wait_host(1);
        check_word("reset request word", host_words[0], 32'h1);
        wait_writes(1);
        check_addr("chip id write addr", wr_addrs[0], 4'd0);
        check_id("chip id write data", wr_data[0], puf_a ^ puf_b);
        wait_lc(1);
        check_id("provisioning identifier", lc_ids[0], '0);
    endtask

    task automatic test_transition_ok();
        id_t req_id;
        req_id    = rand_id();
        lc_answer = 1'b1;
        reset_dut(3'd0);
        wait_lc(1);
        request_transition(req_id, 2);
        check_id("transition identifier", lc_ids[1], req_id);
        wait_host(2);
        check_word("second reset word", host_words[1], 32'h1);
        wait_host(3);
        check_word("restart reset word", host_words[2], 32'h1);
        wait_lc(3);  // held id is still the request id here
        check_id("reprovisioning identifier", lc_ids[2], '0);
    endtask

    task automatic test_transition_fail();
        id_t first_id;
        id_t second_id;
        first_id  = rand_id();
        second_id = rand_id();
        lc_answer = 1'b0;
        reset_dut(3'd0);
        wait_lc(1);
        request_transition(first_id, 2);
        check_id("failed transition identifier", lc_ids[1], first_id);
        idle_cycles(50);
        if (host_words.size() != 1) begin
            $display("Reset request sent after a failed lifecycle transition");
            abort_run();
        end
        request_transition(second_id, 3);
        check_id("retried identifier", lc_ids[2], second_id);
    endtask

    task automatic test_auth_release();
        id_t req_id;
        puf_a     = rand_id();
        puf_b     = rand_id();
        auth_word = rand_id();
        chip_word = puf_a ^ puf_b;
        reset_dut(3'd3);
        wait_host(1);
        present_auth(~auth_word, 1);
        check_addr("auth read addr", rd_addrs[0], 4'd11);
        idle_cycles(20);
        if (rd_addrs.size() != 1) begin
            $display("Memory read after a mismatching authentication ID");
            abort_run();
        end
        present_auth(auth_word, 2);
        check_addr("auth read addr", rd_addrs[1], 4'd11);
        wait_reads(3);
        check_addr("challenge read addr", rd_addrs[2], 4'd0);
        wait_host(2);
        check_word("release word", host_words[1], 32'h10);
        req_id = rand_id();
        request_transition(req_id, 1);  // only served once the release is acked
        check_id("post release identifier", lc_ids[0], req_id);
    endtask

    task automatic test_challenge_abort();
        puf_a     = rand_id();
        puf_b     = rand_id();
        auth_word = rand_id();
        chip_word = ~(puf_a ^ puf_b);  // stored chip id disagrees with the PUFs
        reset_dut(3'd3);
        wait_host(1);
        present_auth(auth_word, 1);
        check_addr("auth read addr", rd_addrs[0], 4'd11);
        wait_reads(2);
        check_addr("challenge read addr", rd_addrs[1], 4'd0);
        idle_cycles(5);
        lc_transition_id         = rand_id();
        lc_transition_request_in = 1'b1;
        idle_cycles(50);
        lc_transition_request_in = 1'b0;
        if (lc_ids.size() != 0) begin
            $display("Lifecycle request issued after a challenge mismatch");
            abort_run();
        end
    endtask

    task automatic test_trunc_boot();
        puf_a     = rand_id();
        puf_b     = rand_id();
        auth_word = rand_id();
        chip_word = puf_a ^ puf_b;
        reset_dut(3'd5);
        wait_host(1);
        present_auth(auth_word, 1);
        check_addr("auth read addr", rd_addrs[0], 4'd13);
        idle_cycles(50);
        if (rd_addrs.size() != 1) begin
            $display("Chip ID read during truncated boot");
            abort_run();
        end
    endtask

    initial begin
        fuse                     = 1'b0;
        lc_state                 = 3'd0;
        lc_transition_id         = '0;
        lc_transition_request_in = 1'b0;
        lc_authentication_id     = '0;
        lc_authentication_valid  = 1'b0;
        puf_a                    = '0;
        puf_b                    = '0;
        auth_word                = '0;
        chip_word                = '0;
        lc_answer                = 1'b0;
        test_provision();
        test_transition_ok();
        test_transition_fail();
        test_auth_release();
        test_challenge_abort();
        test_trunc_boot();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== secure_boot_control.sv ====
// Secure boot control top level.
// Sequencer plus host, lifecycle and secure memory links and the id store.
`timescale 1ns/100ps

module secure_boot_control import boot_pkg::*; (
    input  logic         clk,
    input  logic         fuse,
    input  gpio_word_t   gpio_reg_rdata,
    input  lc_state_t    lc_state,
    input  logic         lc_done,
    input  logic         lc_success,
    input  id_t          lc_transition_id,
    input  logic         lc_transition_request_in,
    input  id_t          lc_authentication_id,
    input  logic         lc_authentication_valid,
    input  id_t          puf_a,
    input  id_t          puf_b,
    input  id_t          rdData,
    input  logic         rdData_valid,
    output logic         gpio_reg_access,
    output gpio_packet_t gpio_reg_packet,
    output logic         lc_transition_request,
    output id_t          lc_identifier,
    output logic         rd_en,
    output logic         wr_en,
    output mem_addr_t    addr,
    output id_t          wrData
);

    // sequencer to links
    logic      host_start;
    host_cmd_t host_cmd;
    logic      host_done;
    logic      lc_start;
    logic      lc_provision;
    logic      lc_link_done;
    logic      lc_link_ok;
    logic      mem_start;
    mem_op_t   mem_op;
    logic      mem_done;
    logic      mem_match;

    // id store
    logic capture_transition;
    logic capture_auth;
    logic latch_chip_id;
    id_t  held_id;
    id_t  chip_id;

    boot_sequencer u_boot_sequencer (.*);

    host_link u_host_link (.*);

    lc_link u_lc_link (.*);

    secure_mem_port u_secure_mem_port (.*);

    boot_id_store u_boot_id_store (.*);

endmodule

// ==== secure_mem_port.sv ====
// Secure memory access port.
// Runs one chip id write or one read-and-compare per start pulse.
`timescale 1ns/100ps

module secure_mem_port import boot_pkg::*; (
    input  logic      clk,
    input  logic      fuse,
    input  logic      mem_start,
    input  mem_op_t   mem_op,
    input  lc_state_t lc_state,
    input  id_t       chip_id,
    input  id_t       held_id,
    input  id_t       rdData,
    input  logic      rdData_valid,
    output logic      mem_done,
    output logic      mem_match,
    output logic      rd_en,
    output logic      wr_en,
    output mem_addr_t addr,
    output id_t       wrData
);

    typedef enum logic [1:0] {
        MP_IDLE,
        MP_READ,
        MP_WRITE
    } mp_phase_t;

    mp_phase_t phase;
    mem_op_t   op_q;
    id_t       ref_id;

    assign ref_id = (op_q == MEM_CHECK_AUTH) ? held_id : chip_id;
    assign wrData = wr_en ? chip_id : '0;  // chip id is the only word written

    always_ff @(posedge clk or negedge fuse) begin
        if (!fuse) begin
            phase     <= MP_IDLE;
            op_q      <= MEM_WRITE_CHIP;
            rd_en     <= 1'b0;
            wr_en     <= 1'b0;
            addr      <= '0;
            mem_done  <= 1'b0;
            mem_match <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            case (phase)
                MP_IDLE: begin
                    if (mem_start) begin
                        op_q <= mem_op;
                        if (mem_op == MEM_WRITE_CHIP) begin
                            wr_en <= 1'b1;
                            addr  <= CHIP_ID_ADDR;
                            phase <= MP_WRITE;
                        end else begin
                            rd_en <= 1'b1;
                            addr  <= (mem_op == MEM_CHECK_AUTH)
                                   ? LC_AUTH_BASE_ADDR + mem_addr_t'(lc_state)
                                   : CHIP_ID_ADDR;
                            phase <= MP_READ;
                        end
                    end
                end
                MP_WRITE: begin  // single cycle write
                    wr_en    <= 1'b0;
                    addr     <= '0;
                    mem_done <= 1'b1;
                    phase    <= MP_IDLE;
                end
                MP_READ: begin
                    if (rdData_valid) begin
                        rd_en     <= 1'b0;
                        addr      <= '0;
                        mem_match <= (rdData == ref_id);
                        mem_done  <= 1'b1;
                        phase     <= MP_IDLE;
                    end
                end
                default: phase <= MP_IDLE;
            endcase
        end
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!fuse)
        !(rd_en && wr_en));

endmodule

// ==== lc_link.sv ====
// Lifecycle controller link.
// Pulses one transition request with its identifier and waits for the result.
`timescale 1ns/100ps

module lc_link import boot_pkg::*; (
    input  logic clk,
    input  logic fuse,
    input  logic lc_start,
    input  logic lc_provision,
    input  id_t  held_id,
    input  logic lc_done,
    input  logic lc_success,
    output logic lc_link_done,
    output logic lc_link_ok,
    output logic lc_transition_request,
    output id_t  lc_identifier
);

    logic busy;  // request sent, result pending
    logic go;

    assign go = lc_start && !busy;

    always_ff @(posedge clk or negedge fuse) begin
        if (!fuse) begin
            busy                  <= 1'b0;
            lc_link_done          <= 1'b0;
            lc_link_ok            <= 1'b0;
            lc_transition_request <= 1'b0;
            lc_identifier         <= '0;
        end else begin
            lc_transition_request <= go;
            lc_link_done          <= busy && lc_done;
            if (go) begin
                busy          <= 1'b1;
                lc_link_ok    <= 1'b0;
                lc_identifier <= lc_provision ? '0 : held_id;  // zero id moves raw to test
            end else begin
                lc_identifier <= '0;
                if (busy && lc_done) begin
                    busy       <= 1'b0;
                    lc_link_ok <= lc_success;
                end
            end
        end
    end

    a_req_pulse: assert property (@(posedge clk) disable iff (!fuse)
        lc_transition_request |=> !lc_transition_request);

endmodule

// ==== host_link.sv ====
// GPIO register link toward the host.
// Writes a request word once, then polls until the matching ack bit is set.
`timescale 1ns/100ps

module host_link import boot_pkg::*; (
    input  logic         clk,
    input  logic         fuse,
    input  logic         host_start,
    input  host_cmd_t    host_cmd,
    input  gpio_word_t   gpio_reg_rdata,
    output logic         host_done,
    output logic         gpio_reg_access,
    output gpio_packet_t gpio_reg_packet
);

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_WRITE,
        PH_POLL
    } phase_t;

    phase_t     phase;
    host_cmd_t  cmd_q;
    logic       rw_q;
    logic [5:0] type_q;
    gpio_word_t word;
    logic       ack;

    assign word = !rw_q ? '0 : (cmd_q == HOST_RELEASE) ? HOST_REL_WORD : HOST_RST_WORD;
    assign ack  = (cmd_q == HOST_RELEASE) ? gpio_reg_rdata[HOST_REL_ACK_BIT]
                                          : gpio_reg_rdata[HOST_RST_ACK_BIT];

    // rw at bit 0, type at 15:10, write word at 71:40
    assign gpio_reg_packet = {32'h0, word, 24'h0, type_q, 9'h0, rw_q};

    always_ff @(posedge clk or negedge fuse) begin
        if (!fuse) begin
            phase           <= PH_IDLE;
            cmd_q           <= HOST_RESET;
            rw_q            <= 1'b0;
            type_q          <= GPIO_ODATA;
            gpio_reg_access <= 1'b0;
            host_done       <= 1'b0;
        end else begin
            host_done <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (host_start) begin
                        cmd_q           <= host_cmd;
                        rw_q            <= 1'b1;
                        type_q          <= GPIO_ODATA;
                        gpio_reg_access <= 1'b1;  // stays up from here on
                        phase           <= PH_WRITE;
                    end
                end
                PH_WRITE: begin
                    rw_q   <= 1'b0;
                    type_q <= GPIO_IDATA;  // read back host status
                    phase  <= PH_POLL;
                end
                PH_POLL: begin
                    if (ack) begin
                        host_done <= 1'b1;
                        phase     <= PH_IDLE;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    a_write_once: assert property (@(posedge clk) disable iff (!fuse)
        gpio_reg_packet[0] |=> !gpio_reg_packet[0]);

endmodule

// ==== boot_sequencer.sv ====
// Secure boot state machine.
// Resets the SoC through the host, then provisions or authenticates
// according to the lifecycle state and serves lifecycle transitions.
`timescale 1ns/100ps

module boot_sequencer import boot_pkg::*; (
    input  logic      clk,
    input  logic      fuse,
    input  lc_state_t lc_state,
    input  logic      lc_transition_request_in,
    input  logic      lc_authentication_valid,
    input  logic      host_done,
    input  logic      lc_link_done,
    input  logic      lc_link_ok,
    input  logic      mem_done,
    input  logic      mem_match,
    output logic      host_start,
    output host_cmd_t host_cmd,
    output logic      lc_start,
    output logic      lc_provision,
    output logic      mem_start,
    output mem_op_t   mem_op,
    output logic      capture_transition,
    output logic      capture_auth,
    output logic      latch_chip_id
);

    boot_state_t state_q;
    boot_state_t state_d;
    logic        entry_q;   // first cycle in state_q

    always_ff @(posedge clk or negedge fuse) begin
        if (!fuse) begin
            state_q <= INIT;
            entry_q <= 1'b0;
        end else begin
            state_q <= state_d;
            entry_q <= (state_d != state_q);
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            INIT: state_d = RESET_SOC;
            RESET_SOC: begin
                if (host_done) begin
                    state_d = (lc_state == LC_RAW) ? CHIPID_WRITE : LC_AUTH_POLL;
                end
            end
            CHIPID_WRITE: if (mem_done) state_d = CHIPID_PROVISION_LC;
            CHIPID_PROVISION_LC: if (lc_link_done) state_d = LC_POLL;  // result ignored
            LC_AUTH_POLL: if (lc_authentication_valid) state_d = LC_AUTH;
            LC_AUTH: begin
                if (mem_done) begin
                    if (!mem_match) begin
                        state_d = LC_AUTH_POLL;
                    end else if (lc_state == LC_EOL) begin
                        state_d = TRUNC_BOOT;
                    end else begin
                        state_d = CHALLENGE_CHIPID;
                    end
                end
            end
            CHALLENGE_CHIPID: begin
                if (mem_done) begin
                    if (!mem_match) begin
                        state_d = ABORT;
                    end else if (lc_state == LC_PROD) begin
                        state_d = NORM_OP_RELEASE;
                    end else begin
                        state_d = LC_POLL;
                    end
                end
            end
            NORM_OP_RELEASE: if (host_done) state_d = LC_POLL;
            LC_POLL: if (lc_transition_request_in) state_d = LC_TRANSITION;
            LC_TRANSITION: begin
                if (lc_link_done) begin
                    state_d = lc_link_ok ? RESET_SOC2 : LC_POLL;
                end
            end
            RESET_SOC2: if (host_done) state_d = INIT;  // full restart
            default: state_d = state_q;                 // trunc boot and abort hold
        endcase
    end

    // link requests fire once, on state entry
    assign host_start = entry_q && (state_q inside {RESET_SOC, NORM_OP_RELEASE, RESET_SOC2});
    assign host_cmd   = (state_q == NORM_OP_RELEASE) ? HOST_RELEASE : HOST_RESET;

    assign lc_start     = entry_q && (state_q inside {CHIPID_PROVISION_LC, LC_TRANSITION});
    assign lc_provision = (state_q == CHIPID_PROVISION_LC);

    assign mem_start = entry_q && (state_q inside {CHIPID_WRITE, LC_AUTH, CHALLENGE_CHIPID});

    always_comb begin
        case (state_q)
            LC_AUTH:          mem_op = MEM_CHECK_AUTH;
            CHALLENGE_CHIPID: mem_op = MEM_CHECK_CHIP;
            default:          mem_op = MEM_WRITE_CHIP;
        endcase
    end

    assign capture_transition = (state_q == LC_POLL) && lc_transition_request_in;
    assign capture_auth       = (state_q == LC_AUTH_POLL) && lc_authentication_valid;
    assign latch_chip_id      = entry_q && (state_q inside {CHIPID_WRITE, CHALLENGE_CHIPID});

    // only one link may be kicked per cycle
    a_one_start: assert property (@(posedge clk) disable iff (!fuse)
        $onehot0({host_start, lc_start, mem_start}));

endmodule

// ==== boot_id_store.sv ====
// Holds the requester id for lifecycle work and the PUF derived chip id.
`timescale 1ns/100ps

module boot_id_store import boot_pkg::*; (
    input  logic clk,
    input  logic fuse,
    input  logic capture_transition,
    input  logic capture_auth,
    input  logic latch_chip_id,
    input  id_t  lc_transition_id,
    input  id_t  lc_authentication_id,
    input  id_t  puf_a,
    input  id_t  puf_b,
    output id_t  held_id,
    output id_t  chip_id
);

    // transition and auth ids share one holding register
    always_ff @(posedge clk or negedge fuse) begin
        if (!fuse) begin
            held_id <= '0;
            chip_id <= '0;
        end else begin
            if (capture_transition) begin
                held_id <= lc_transition_id;
            end else if (capture_auth) begin
                held_id <= lc_authentication_id;
            end
            if (latch_chip_id) begin
                chip_id <= puf_a ^ puf_b;
            end
        end
    end

endmodule

// ==== boot_pkg.sv ====
// Shared widths, codes and enums for the secure boot sequencer.
// Covers the GPIO host words, lifecycle codes and secure memory map.

package boot_pkg;

    typedef logic [255:0] id_t;          // lifecycle ids, puf responses, memory words
    typedef logic [31:0]  gpio_word_t;
    typedef logic [103:0] gpio_packet_t;
    typedef logic [3:0]   mem_addr_t;    // 16 word secure memory
    typedef logic [2:0]   lc_state_t;

    localparam lc_state_t LC_RAW  = 3'd0;
    localparam lc_state_t LC_PROD = 3'd3;
    localparam lc_state_t LC_EOL  = 3'd5;

    localparam logic [5:0] GPIO_ODATA = 6'h0;
    localparam logic [5:0] GPIO_IDATA = 6'h5;

    localparam gpio_word_t HOST_RST_WORD    = 32'h1;
    localparam int         HOST_RST_ACK_BIT = 1;
    localparam gpio_word_t HOST_REL_WORD    = 32'h10;
    localparam int         HOST_REL_ACK_BIT = 5;

    localparam mem_addr_t CHIP_ID_ADDR      = 4'h0;
    localparam mem_addr_t LC_AUTH_BASE_ADDR = 4'h8;  // plus lc state

    typedef enum logic {
        HOST_RESET,
        HOST_RELEASE
    } host_cmd_t;

    typedef enum logic [1:0] {
        MEM_WRITE_CHIP,
        MEM_CHECK_CHIP,
        MEM_CHECK_AUTH
    } mem_op_t;

    typedef enum logic [3:0] {
        INIT, RESET_SOC, LC_AUTH_POLL, LC_AUTH, CHIPID_WRITE, CHIPID_PROVISION_LC,
        CHALLENGE_CHIPID, NORM_OP_RELEASE, LC_POLL, LC_TRANSITION, RESET_SOC2,
        TRUNC_BOOT, ABORT
    } boot_state_t;

endpackage
